// ==== Bender.yml ====
package:
  name: romulus_api

sources:
  - include_dirs:
      - include
    files:
      - src/romulus_pkg.sv
      - src/block_counter.sv
      - src/domain_tracker.sv
      - src/api_fsm.sv
      - src/romulus_api_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/romulus_api_chk.sv
      - verification/tb_romulus_api.sv

// ==== include/romulus_defines.svh ====
`ifndef ROMULUS_DEFINES_SVH
`define ROMULUS_DEFINES_SVH

// public, secret and output ports share one word width
`define BUSW 32

// a 16-byte block arrives as four 32-bit words
`define BEATS_PER_BLOCK 4

`define BLOCK_BYTES 16 // length consumed per block

// beat counter runs 1..4, binary
`define CNT_W 3

`define SEGLEN_W 16 // low half of a segment header

`endif

// ==== sim.f ====
+incdir+include
src/romulus_pkg.sv
src/block_counter.sv
src/domain_tracker.sv
src/api_fsm.sv
src/romulus_api_top.sv
verification/romulus_api_chk.sv
verification/tb_romulus_api.sv

// ==== src/api_fsm.sv ====
`timescale 1ns/10ps
`include "romulus_defines.svh"

module api_fsm (
   input  logic                   clk,
   input  logic                   neg_rst,
   input  romulus_pkg::bus_word_t pdi_data,
   input  romulus_pkg::bus_word_t sdi_data,
   input  romulus_pkg::bus_word_t pdo,
   input  logic                   pdi_valid,
   input  logic                   sdi_valid,
   input  logic                   pdo_ready,
   output logic                   pdi_ready,
   output logic                   sdi_ready,
   output logic                   pdo_valid,
   output romulus_pkg::bus_word_t pdo_data,
   output romulus_pkg::dp_ctrl_t  ctrl,
   output logic                   cnt_load,
   output logic [`SEGLEN_W-1:0]   load_len,
   output logic                   beat,
   input  logic                   block_end,
   input  logic                   seg_done,
   output logic                   ad_block,
   output logic                   msg_block,
   output logic                   nonce_done
);

   romulus_pkg::api_state_t state;
   romulus_pkg::api_state_t state_n;
   romulus_pkg::instr_t     instr;
   romulus_pkg::instr_t     instr_n;
   romulus_pkg::instr_t     pdi_instr;
   romulus_pkg::instr_t     sdi_instr;
   romulus_pkg::seg_hdr_t   pdi_hdr;
   romulus_pkg::seg_hdr_t   sdi_hdr;
   romulus_pkg::seg_hdr_t   out_hdr;
   romulus_pkg::seg_type_t  msg_type;
   logic                    dec;
   logic                    msg_xfer;

   assign pdi_instr = romulus_pkg::instr_t'(pdi_data[`BUSW-1 -: 8]);
   assign sdi_instr = romulus_pkg::instr_t'(sdi_data[`BUSW-1 -: 8]);
   assign pdi_hdr   = romulus_pkg::seg_hdr_t'(pdi_data);
   assign sdi_hdr   = romulus_pkg::seg_hdr_t'(sdi_data);
   assign load_len  = pdi_hdr.length;

   assign dec      = (instr == romulus_pkg::decn);
   assign msg_type = dec ? romulus_pkg::cipher : romulus_pkg::plain;
   assign msg_xfer = pdi_valid && pdo_ready; // in and out move in lockstep

   // header for the output port, other message type
   always_comb begin
      out_hdr          = pdi_hdr;
      out_hdr.seg_type = dec ? romulus_pkg::plain : romulus_pkg::cipher;
      out_hdr.partial  = 1'b0;
      out_hdr.spare    = dec ? pdi_hdr.last : 1'b0;
   end

   always_ff @(posedge clk) begin
      if (!neg_rst) begin
         state <= romulus_pkg::idle;
         instr <= romulus_pkg::encn;
      end else begin
         state <= state_n;
         instr <= instr_n;
      end
   end

   always_comb begin
      state_n    = state;
      instr_n    = instr;
      pdi_ready  = 1'b0;
      sdi_ready  = 1'b0;
      pdo_valid  = 1'b0;
      pdo_data   = pdo;
      ctrl       = '0;
      cnt_load   = 1'b0;
      beat       = 1'b0;
      ad_block   = 1'b0;
      msg_block  = 1'b0;
      nonce_done = 1'b0;
      case (state)
         romulus_pkg::idle: begin
            if (pdi_valid && neg_rst) begin // nothing taken while in reset
               pdi_ready = 1'b1; // unknown codes are swallowed here
               case (pdi_instr)
                  romulus_pkg::actkey: begin
                     if (sdi_valid && (sdi_instr == romulus_pkg::ldkey)) begin
                        sdi_ready = 1'b1;
                        state_n   = romulus_pkg::key_header;
                     end
                  end
                  romulus_pkg::encn, romulus_pkg::decn: begin
                     instr_n    = pdi_instr;
                     ctrl.z_rst = 1'b1;
                     ctrl.s_rst = 1'b1;
                     state_n    = romulus_pkg::ad_header;
                  end
                  default: begin
                     state_n = romulus_pkg::idle;
                  end
               endcase
            end
         end
         romulus_pkg::key_header: begin
            if (sdi_valid) begin
               sdi_ready = 1'b1;
               if (sdi_hdr.seg_type == romulus_pkg::key) begin
                  state_n = romulus_pkg::store_key;
               end
            end
         end
         romulus_pkg::store_key: begin
            if (sdi_valid) begin
               sdi_ready  = 1'b1;
               beat       = 1'b1;
               ctrl.x_rst = 1'b1; // key word into x
               if (block_end) begin
                  state_n = romulus_pkg::idle;
               end
            end
         end
         romulus_pkg::ad_header: begin
            if (pdi_valid) begin
               pdi_ready = 1'b1;
               if (pdi_hdr.seg_type == romulus_pkg::ad) begin
                  cnt_load = 1'b1;
                  state_n  = romulus_pkg::store_ad;
               end
            end
         end
         romulus_pkg::store_ad: begin
            if (pdi_valid) begin
               pdi_ready = 1'b1;
               beat      = 1'b1;
               ctrl.s_en = 1'b1;
               if (block_end) begin
                  ctrl.z_en = 1'b1;
                  ctrl.x_en = 1'b1;
                  ad_block  = 1'b1;
                  if (seg_done) begin
                     state_n = romulus_pkg::nonce_header;
                  end
               end
            end
         end
         romulus_pkg::nonce_header: begin
            if (pdi_valid) begin
               pdi_ready = 1'b1;
               if (pdi_hdr.seg_type == romulus_pkg::npub) begin
                  state_n = romulus_pkg::store_nonce;
               end
            end
         end
         romulus_pkg::store_nonce: begin
            if (pdi_valid) begin
               pdi_ready  = 1'b1;
               beat       = 1'b1;
               ctrl.y_rst = 1'b1;
               ctrl.y_enc = 1'b1;
               if (block_end) begin
                  nonce_done = 1'b1;
                  state_n    = romulus_pkg::msg_header;
               end
            end
         end
         romulus_pkg::msg_header: begin
            pdo_data = out_hdr;
            if (msg_xfer) begin
               pdi_ready = 1'b1;
               pdo_valid = 1'b1;
               if (pdi_hdr.seg_type == msg_type) begin
                  cnt_load = 1'b1;
                  state_n  = romulus_pkg::store_msg;
               end
            end
         end
         romulus_pkg::store_msg: begin
            if (msg_xfer) begin
               pdi_ready  = 1'b1;
               pdo_valid  = 1'b1;
               beat       = 1'b1;
               ctrl.s_enc = 1'b1;
               if (block_end) begin
                  ctrl.x_enc = 1'b1;
                  ctrl.y_enc = 1'b1;
                  ctrl.z_enc = 1'b1;
                  msg_block  = 1'b1;
                  if (seg_done) begin
                     state_n = romulus_pkg::idle;
                  end
               end
            end
         end
         default: begin
            state_n = romulus_pkg::idle;
         end
      endcase
   end

endmodule

// ==== src/block_counter.sv ====
`timescale 1ns/10ps
`include "romulus_defines.svh"

module block_counter (
   input  logic                 clk,
   input  logic                 neg_rst,
   input  logic                 load,
   input  logic [`SEGLEN_W-1:0] load_len,
   input  logic                 beat,
   output logic                 block_end,
   output logic                 seg_done
);

   logic [`CNT_W-1:0]    cnt;
   logic [`SEGLEN_W-1:0] remain;
   logic                 first_beat;

   assign first_beat = (cnt == `CNT_W'(1));
   assign block_end  = (cnt == `CNT_W'(`BEATS_PER_BLOCK));
   // remain was already reduced on beat 1 of this block
   assign seg_done   = block_end && (remain == '0);

   always_ff @(posedge clk) begin
      if (!neg_rst) begin
         cnt <= `CNT_W'(1);
      end else if (load) begin
         cnt <= `CNT_W'(1);
      end else if (beat) begin
         if (block_end) begin
            cnt <= `CNT_W'(1); // wrap for next block
         end else begin
            cnt <= cnt + `CNT_W'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!neg_rst) begin
         remain <= '0;
      end else if (load) begin
         remain <= load_len;
      end else if (beat && first_beat) begin
         remain <= remain - `SEGLEN_W'(`BLOCK_BYTES);
      end
   end

endmodule

// ==== src/domain_tracker.sv ====
`timescale 1ns/10ps

module domain_tracker (
   input  logic                 clk,
   input  logic                 neg_rst,
   input  logic                 ad_block,
   input  logic                 msg_block,
   input  logic                 nonce_done,
   input  logic                 seg_done,
   output romulus_pkg::domain_t domain
);

   romulus_pkg::domain_t nonce_dom; // domain used once the nonce is in

   always_ff @(posedge clk) begin
      if (!neg_rst) begin
         domain    <= romulus_pkg::dom_none;
         nonce_dom <= romulus_pkg::dom_none;
      end else begin
         if (ad_block) begin
            if (seg_done) begin
               domain    <= romulus_pkg::ad_final;
               nonce_dom <= romulus_pkg::ad_final;
            end else begin
               domain <= romulus_pkg::ad_normal;
            end
         end else if (nonce_done) begin
            domain <= nonce_dom;
         end else if (msg_block) begin
            if (seg_done) begin
               domain <= romulus_pkg::msg_final;
            end else begin
               domain <= romulus_pkg::msg_normal;
            end
         end
      end
   end

endmodule

// ==== src/romulus_api_top.sv ====
`timescale 1ns/10ps
`include "romulus_defines.svh"

module romulus_api_top (
   input  logic                   clk,
   input  logic                   neg_rst,
   input  romulus_pkg::bus_word_t pdi_data,
   input  logic                   pdi_valid,
   output logic                   pdi_ready,
   input  romulus_pkg::bus_word_t sdi_data,
   input  logic                   sdi_valid,
   output logic                   sdi_ready,
   input  romulus_pkg::bus_word_t pdo,
   output romulus_pkg::bus_word_t pdo_data,
   output logic                   pdo_valid,
   input  logic                   pdo_ready,
   output romulus_pkg::dp_ctrl_t  ctrl,
   output romulus_pkg::domain_t   domain
);

   logic                 cnt_load;
   logic [`SEGLEN_W-1:0] load_len;
   logic                 beat;
   logic                 block_end;
   logic                 seg_done;
   logic                 ad_block;
   logic                 msg_block;
   logic                 nonce_done;

   api_fsm i_api_fsm (
      .clk        (clk),
      .neg_rst    (neg_rst),
      .pdi_data   (pdi_data),
      .sdi_data   (sdi_data),
      .pdo        (pdo),
      .pdi_valid  (pdi_valid),
      .sdi_valid  (sdi_valid),
      .pdo_ready  (pdo_ready),
      .pdi_ready  (pdi_ready),
      .sdi_ready  (sdi_ready),
      .pdo_valid  (pdo_valid),
      .pdo_data   (pdo_data),
      .ctrl       (ctrl),
      .cnt_load   (cnt_load),
      .load_len   (load_len),
      .beat       (beat),
      .block_end  (block_end),
      .seg_done   (seg_done),
      .ad_block   (ad_block),
      .msg_block  (msg_block),
      .nonce_done (nonce_done)
   );

   block_counter i_block_counter (
      .clk       (clk),
      .neg_rst   (neg_rst),
      .load      (cnt_load),
      .load_len  (load_len),
      .beat      (beat),
      .block_end (block_end),
      .seg_done  (seg_done)
   );

   domain_tracker i_domain_tracker (
      .clk        (clk),
      .neg_rst    (neg_rst),
      .ad_block   (ad_block),
      .msg_block  (msg_block),
      .nonce_done (nonce_done),
      .seg_done   (seg_done),
      .domain     (domain)
   );

endmodule

// ==== src/romulus_pkg.sv ====
`include "romulus_defines.svh"

package romulus_pkg;

   typedef logic [`BUSW-1:0] bus_word_t;

   // instruction codes sit in the top byte of the word
   typedef enum logic [7:0] {
      ldkey  = 8'h40,
      actkey = 8'h70,
      encn   = 8'h20,
      decn   = 8'h30
   } instr_t;

   typedef enum logic [3:0] {
      ad     = 4'd1,
      plain  = 4'd4,
      cipher = 4'd5,
      key    = 4'd12,
      npub   = 4'd13
   } seg_type_t;

   typedef enum logic [7:0] {
      dom_none   = 8'h00,
      msg_normal = 8'h04,
      ad_normal  = 8'h08,
      msg_final  = 8'h14,
      ad_final   = 8'h18
   } domain_t;

   typedef enum logic [3:0] {
      idle,
      key_header,
      store_key,
      ad_header,
      store_ad,
      nonce_header,
      store_nonce,
      msg_header,
      store_msg
   } api_state_t;

   typedef struct packed {
      seg_type_t            seg_type;
      logic                 eot;
      logic                 partial;
      logic                 last;
      logic                 spare;
      logic [7:0]           reserved;
      logic [`SEGLEN_W-1:0] length;
   } seg_hdr_t;

   // strobes for the x, y, z and s registers of the datapath
   typedef struct packed {
      logic x_rst;
      logic x_enc;
      logic x_en;
      logic y_rst;
      logic y_enc;
      logic y_en;
      logic z_rst;
      logic z_enc;
      logic z_en;
      logic s_rst;
      logic s_enc;
      logic s_en;
   } dp_ctrl_t;

endpackage

// ==== verification/romulus_api_chk.sv ====
`timescale 1ns/10ps

module romulus_api_chk (
   input logic                  clk,
   input logic                  neg_rst,
   input logic                  pdi_valid,
   input logic                  pdi_ready,
   input logic                  sdi_valid,
   input logic                  sdi_ready,
   input logic                  pdo_valid,
   input logic                  pdo_ready,
   input romulus_pkg::dp_ctrl_t ctrl
);

   int fail_cnt = 0; // read by the testbench

   pdi_ready_needs_valid: assert property (@(posedge clk) disable iff (!neg_rst)
      pdi_ready |-> pdi_valid)
      else begin
         $error("pdi_ready high while pdi_valid is low");
         fail_cnt++;
      end

   sdi_ready_needs_valid: assert property (@(posedge clk) disable iff (!neg_rst)
      sdi_ready |-> sdi_valid)
      else begin
         $error("sdi_ready high while sdi_valid is low");
         fail_cnt++;
      end

   pdo_valid_needs_ready: assert property (@(posedge clk) disable iff (!neg_rst)
      pdo_valid |-> pdo_ready)
      else begin
         $error("pdo_valid high while pdo_ready is low");
         fail_cnt++;
      end

   ctrl_quiet_in_reset: assert property (@(posedge clk) !neg_rst |-> (ctrl == '0))
      else begin
         $error("datapath strobes active during reset");
         fail_cnt++;
      end

endmodule

bind romulus_api_top romulus_api_chk i_romulus_api_chk (.*);

// ==== verification/tb_romulus_api.sv ====
`timescale 1ns/10ps
`include "romulus_defines.svh"

module tb_romulus_api;

   localparam int N_RUNS = 6;
   localparam romulus_pkg::bus_word_t PDO_MASK = 32'h5a3c_96e1;

   typedef struct packed {
      romulus_pkg::api_state_t st;
      logic [`CNT_W-1:0]       beat;
      logic [`SEGLEN_W-1:0]    blocks;
      logic                    dec;
      romulus_pkg::domain_t    dom;
      romulus_pkg::domain_t    nonce_dom;
   } model_t;

   typedef struct packed {
      logic                   pdi_rdy;
      logic                   sdi_rdy;
      logic                   out_vld;
      romulus_pkg::bus_word_t word;
      romulus_pkg::dp_ctrl_t  ctrl;
      model_t                 nxt;
   } expect_t;

   logic                   clk = 1'b0;
   logic                   neg_rst;
   romulus_pkg::bus_word_t pdi_data;
   logic                   pdi_valid;
   logic                   pdi_ready;
   romulus_pkg::bus_word_t sdi_data;
   logic                   sdi_valid;
   logic                   sdi_ready;
   romulus_pkg::bus_word_t pdo;
   romulus_pkg::bus_word_t pdo_data;
   logic                   pdo_valid;
   logic                   pdo_ready;
   romulus_pkg::dp_ctrl_t  ctrl;
   romulus_pkg::domain_t   domain;

   model_t      model;
   logic [31:0] lcg_state;
   logic        stall_en;
   int          out_cnt = 0;
   int          sdi_cnt = 0;
   int          total_words = 0;
   int          ad_blk [N_RUNS];
   int          msg_blk [N_RUNS];

   always #50 clk = ~clk;

   assign pdo = pdi_data ^ PDO_MASK; // stand-in for the cipher datapath

   romulus_api_top i_romulus_api_top (
      .clk       (clk),
      .neg_rst   (neg_rst),
      .pdi_data  (pdi_data),
      .pdi_valid (pdi_valid),
      .pdi_ready (pdi_ready),
      .sdi_data  (sdi_data),
      .sdi_valid (sdi_valid),
      .sdi_ready (sdi_ready),
      .pdo       (pdo),
      .pdo_data  (pdo_data),
      .pdo_valid (pdo_valid),
      .pdo_ready (pdo_ready),
      .ctrl      (ctrl),
      .domain    (domain)
   );

   function automatic logic [31:0] rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic ready_draw();
      logic [31:0] r;
      r = rand_word();
      return r[17:16] != 2'b00; // ready three times in four
   endfunction

   function automatic int block_draw();
      logic [31:0] r;
      r = rand_word();
      return 1 + int'(r[23:16]) % 3;
   endfunction

   // expected outputs for one cycle, plus the model state after the edge
   function automatic expect_t ref_model(model_t m, logic pv, romulus_pkg::bus_word_t pd,
                                         logic sv, romulus_pkg::bus_word_t sd, logic pr,
                                         romulus_pkg::bus_word_t pin);
      expect_t               e;
      romulus_pkg::seg_hdr_t h;
      romulus_pkg::seg_hdr_t o;
      logic                  last_beat;
      e         = '0;
      e.nxt     = m;
      e.word    = pin;
      h         = romulus_pkg::seg_hdr_t'(pd);
      last_beat = (m.beat == `CNT_W'(`BEATS_PER_BLOCK));
      case (m.st)
         romulus_pkg::idle: begin
            if (pv) begin
               e.pdi_rdy = 1'b1;
               if (pd[31:24] == romulus_pkg::actkey) begin
                  if (sv && (sd[31:24] == romulus_pkg::ldkey)) begin
                     e.sdi_rdy = 1'b1;
                     e.nxt.st  = romulus_pkg::key_header;
                  end
               end else if (pd[31:24] == romulus_pkg::encn || pd[31:24] == romulus_pkg::decn) begin
                  e.ctrl.z_rst = 1'b1;
                  e.ctrl.s_rst = 1'b1;
                  e.nxt.dec    = (pd[31:24] == romulus_pkg::decn);
                  e.nxt.st     = romulus_pkg::ad_header;
               end
            end
         end
         romulus_pkg::key_header: begin
            if (sv) begin
               e.sdi_rdy = 1'b1;
               if (sd[31:28] == romulus_pkg::key) begin
                  e.nxt.st   = romulus_pkg::store_key;
                  e.nxt.beat = `CNT_W'(1);
               end
            end
         end
         romulus_pkg::ad_header, romulus_pkg::nonce_header: begin
            if (pv) begin
               e.pdi_rdy = 1'b1;
               if (m.st == romulus_pkg::ad_header && h.seg_type == romulus_pkg::ad) begin
                  e.nxt.st     = romulus_pkg::store_ad;
                  e.nxt.blocks = h.length / `BLOCK_BYTES;
                  e.nxt.beat   = `CNT_W'(1);
               end else if (m.st == romulus_pkg::nonce_header &&
                            h.seg_type == romulus_pkg::npub) begin
                  e.nxt.st   = romulus_pkg::store_nonce;
                  e.nxt.beat = `CNT_W'(1);
               end
            end
         end
         romulus_pkg::msg_header: begin
            o          = h;
            o.seg_type = m.dec ? romulus_pkg::plain : romulus_pkg::cipher;
            o.partial  = 1'b0;
            o.spare    = m.dec ? h.last : 1'b0;
            e.word     = o;
            if (pv && pr) begin
               e.pdi_rdy = 1'b1;
               e.out_vld = 1'b1;
               if (h.seg_type == (m.dec ? romulus_pkg::cipher : romulus_pkg::plain)) begin
                  e.nxt.st     = romulus_pkg::store_msg;
                  e.nxt.blocks = h.length / `BLOCK_BYTES;
                  e.nxt.beat   = `CNT_W'(1);
               end
            end
         end
         default: begin // the four data states
            if ((m.st == romulus_pkg::store_key) ? sv :
                (m.st == romulus_pkg::store_msg) ? (pv && pr) : pv) begin
               e.nxt.beat = last_beat ? `CNT_W'(1) : m.beat + `CNT_W'(1);
               case (m.st)
                  romulus_pkg::store_key: begin
                     e.sdi_rdy    = 1'b1;
                     e.ctrl.x_rst = 1'b1;
                     if (last_beat) e.nxt.st = romulus_pkg::idle;
                  end
                  romulus_pkg::store_ad: begin
                     e.pdi_rdy   = 1'b1;
                     e.ctrl.s_en = 1'b1;
                     if (last_beat) begin
                        e.ctrl.z_en  = 1'b1;
                        e.ctrl.x_en  = 1'b1;
                        e.nxt.blocks = m.blocks - 1;
                        e.nxt.dom    = romulus_pkg::ad_normal;
                        if (m.blocks == 1) begin
                           e.nxt.dom       = romulus_pkg::ad_final;
                           e.nxt.nonce_dom = romulus_pkg::ad_final;
                           e.nxt.st        = romulus_pkg::nonce_header;
                        end
                     end
                  end
                  romulus_pkg::store_nonce: begin
                     e.pdi_rdy    = 1'b1;
                     e.ctrl.y_rst = 1'b1;
                     e.ctrl.y_enc = 1'b1;
                     if (last_beat) begin
                        e.nxt.dom = m.nonce_dom;
                        e.nxt.st  = romulus_pkg::msg_header;
                     end
                  end
                  default: begin
                     e.pdi_rdy    = 1'b1;
                     e.out_vld    = 1'b1;
                     e.ctrl.s_enc = 1'b1;
                     if (last_beat) begin
                        e.ctrl.x_enc = 1'b1;
                        e.ctrl.y_enc = 1'b1;
                        e.ctrl.z_enc = 1'b1;
                        e.nxt.blocks = m.blocks - 1;
                        e.nxt.dom    = romulus_pkg::msg_normal;
                        if (m.blocks == 1) begin
                           e.nxt.dom = romulus_pkg::msg_final;
                           e.nxt.st  = romulus_pkg::idle;
                        end
                     end
                  end
               endcase
            end
         end
      endcase
      return e;
   endfunction

   task automatic fail_value(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch");
   endtask

   task automatic stop_run(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "test aborted");
   endtask

   task automatic check_word(input romulus_pkg::bus_word_t got, input romulus_pkg::bus_word_t exp);
      if (got !== exp) fail_value($sformatf("pdo_data %h, expected %h", got, exp));
   endtask

   task automatic check_ctrl(input romulus_pkg::dp_ctrl_t got, input romulus_pkg::dp_ctrl_t exp);
      if (got !== exp) fail_value($sformatf("ctrl %b, expected %b", got, exp));
   endtask

   task automatic check_domain(input romulus_pkg::domain_t got, input romulus_pkg::domain_t exp);
      if (got !== exp) fail_value($sformatf("domain %h, expected %h", got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) fail_value($sformatf("%s %b, expected %b", name, got, exp));
   endtask

   always @(posedge clk) begin : compare
      expect_t e;
      if (!neg_rst) begin
         model      = '0;
         model.st   = romulus_pkg::idle;
         model.beat = `CNT_W'(1);
      end else begin
         e = ref_model(model, pdi_valid, pdi_data, sdi_valid, sdi_data, pdo_ready, pdo);
         check_flag("pdi_ready", pdi_ready, e.pdi_rdy);
         check_flag("sdi_ready", sdi_ready, e.sdi_rdy);
         check_flag("pdo_valid", pdo_valid, e.out_vld);
         check_ctrl(ctrl, e.ctrl);
         check_domain(domain, model.dom); // register, pre-edge value
         if (e.out_vld) begin
            check_word(pdo_data, e.word);
         end
         if (pdo_valid && pdo_ready) out_cnt++;
         if (sdi_valid && sdi_ready) sdi_cnt++;
         if (i_romulus_api_top.i_romulus_api_chk.fail_cnt != 0) begin
            stop_run("a bound assertion on the handshakes or reset failed");
         end
         model = e.nxt;
      end
   end

   task automatic send_pdi(input romulus_pkg::bus_word_t w);
      pdi_data  = w;
      pdi_valid = 1'b1;
      pdo_ready = stall_en ? ready_draw() : 1'b1;
      forever begin
         @(posedge clk);
         if (pdi_ready) break;
         @(negedge clk);
         pdo_ready = stall_en ? ready_draw() : 1'b1;
      end
      @(negedge clk);
      pdi_valid = 1'b0;
   endtask

   task automatic send_sdi(input romulus_pkg::bus_word_t w);
      sdi_data  = w;
      sdi_valid = 1'b1;
      do @(posedge clk); while (!sdi_ready);
      @(negedge clk);
      sdi_valid = 1'b0;
   endtask

   function automatic romulus_pkg::bus_word_t make_hdr(input romulus_pkg::seg_type_t t,
                                                       input int blocks);
      romulus_pkg::seg_hdr_t h;
      h          = romulus_pkg::seg_hdr_t'(rand_word()); // random flag bits
      h.seg_type = t;
      h.length   = `SEGLEN_W'(blocks * `BLOCK_BYTES);
      return h;
   endfunction

   task automatic load_key();
      int sdi_before;
      int i;
      sdi_before = sdi_cnt;
      pdi_data   = {romulus_pkg::actkey, 24'h0};
      sdi_data   = {romulus_pkg::ldkey, 24'h0};
      pdi_valid  = 1'b1;
      sdi_valid  = 1'b1;
      do @(posedge clk); while (!pdi_ready);
      @(negedge clk);
      pdi_valid = 1'b0;
      sdi_valid = 1'b0;
      send_sdi(make_hdr(romulus_pkg::key, 1));
      for (i = 0; i < `BEATS_PER_BLOCK; i++) send_sdi(rand_word());
      if (sdi_cnt - sdi_before != 6) stop_run("key load did not take six secret words");
   endtask

   task automatic run_aead(input logic dec, input int n_ad, input int n_msg, input logic stall);
      int out_before;
      int i;
      stall_en = stall;
      send_pdi({dec ? romulus_pkg::decn : romulus_pkg::encn, 24'h0});
      send_pdi(make_hdr(romulus_pkg::ad, n_ad));
      for (i = 0; i < n_ad * `BEATS_PER_BLOCK; i++) send_pdi(rand_word());
      send_pdi(make_hdr(romulus_pkg::npub, 1));
      for (i = 0; i < `BEATS_PER_BLOCK; i++) send_pdi(rand_word());
      out_before = out_cnt;
      send_pdi(make_hdr(dec ? romulus_pkg::cipher : romulus_pkg::plain, n_msg));
      for (i = 0; i < n_msg * `BEATS_PER_BLOCK; i++) send_pdi(rand_word());
      stall_en  = 1'b0;
      pdo_ready = 1'b1;
      if (out_cnt - out_before != 1 + n_msg * `BEATS_PER_BLOCK) begin
         stop_run("message output lost or repeated words");
      end
   endtask

   initial begin : stimulus
      int i;
      int words;
      neg_rst   = 1'b0;
      pdi_data  = {romulus_pkg::encn, 24'h0}; // offered during reset, must be ignored
      pdi_valid = 1'b1;
      sdi_data  = '0;
      sdi_valid = 1'b0;
      pdo_ready = 1'b1;
      stall_en  = 1'b0;
      lcg_state = 32'hb4cd;
      words     = 8; // key load and the unknown instruction
      for (i = 0; i < N_RUNS; i++) begin
         ad_blk[i]  = block_draw();
         msg_blk[i] = block_draw();
         words += 4 + `BEATS_PER_BLOCK * (ad_blk[i] + msg_blk[i] + 1);
      end
      total_words = words;
      repeat (8) @(negedge clk);
      neg_rst   = 1'b1;
      pdi_valid = 1'b0;
      pdi_data  = '0;
      @(negedge clk);
      load_key();
      send_pdi(32'h5500_0000); // not an instruction code
      for (i = 0; i < N_RUNS; i++) begin
         run_aead(i % 2 == 1, ad_blk[i], msg_blk[i], i >= 2); // stalls from run 2 on
      end
      repeat (4) @(negedge clk);
      if (i_romulus_api_top.i_romulus_api_chk.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("SIMULATION FAILED");
         $fatal(1, "errors found");
      end
   end

   initial begin : watchdog
      wait (total_words > 0);
      #(total_words * 400 + 20000);
      $display("Error at %0t ns: watchdog timeout, the tests did not finish", $time);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

endmodule
